// File: hw/rr_axil_pkg.sv
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// AXI-Lite write request types seen by the recorders
////////////////////////////////////////////////////////////////////////////

package rr_axil_pkg;

  // Byte address carried on the AW channel
  typedef logic [31:0] axil_addr_t;

  // One data beat carried on the W channel
  // Strobes are not monitored, all four bytes are logged
  typedef logic [31:0] axil_data_t;

  // Payload of one write request
  // Address sits in the upper word, data in the lower word
  typedef struct packed {
    axil_addr_t addr;
    axil_data_t data;
  } axil_wreq_t;

  // Both shell channels use this same payload
  // ocl and sda differ only by the tag added in the merge stage

endpackage

`default_nettype wire

// File: hw/rr_log_pkg.sv
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// Log entry and record formats
////////////////////////////////////////////////////////////////////////////

package rr_log_pkg;

  // Recorded channels, fixed by the shell interface
  localparam int CHAN_CNT = 2;

  // Channel tag, one bit covers both channels
  typedef logic chan_id_t;

  localparam chan_id_t CHAN_OCL = 1'b0;
  localparam chan_id_t CHAN_SDA = 1'b1;

  // Raw entry as it leaves a recorder FIFO
  typedef struct packed {
    rr_axil_pkg::axil_wreq_t req;
  } log_entry_t;

  // Entry after the merge, 65 bits
  typedef struct packed {
    chan_id_t   chan;
    log_entry_t entry;
  } tagged_entry_t;

  // Global record sequence number, wraps at 16 bits
  typedef logic [15:0] rr_seq_t;

  // XOR of all address and data bytes, channel tag folded into bit 0
  typedef logic [7:0] rr_check_t;

  // Finished record as written to trace storage, 89 bits
  typedef struct packed {
    rr_seq_t    seq;
    chan_id_t   chan;
    rr_check_t  check;
    log_entry_t entry;
  } rr_record_t;

  ////////////////////////////////////////////////////////////////////////////
  // Pipeline sizing
  ////////////////////////////////////////////////////////////////////////////

  // Per channel log FIFO, power of two
  localparam int LOG_FIFO_DEPTH = 4;

  // Storage credits granted at reset
  localparam int WB_CREDITS = 4;

  // Holds 0 up to WB_CREDITS
  typedef logic [2:0] credit_cnt_t;

endpackage

`default_nettype wire

// File: hw/axil_mstr_recorder.sv
`timescale 1ns/1ps
`default_nettype none

module axil_mstr_recorder (
  input  logic                    clk,
  input  logic                    rst_n,
  // Shell side
  input  logic                    in_valid,
  output logic                    in_ready,
  input  rr_axil_pkg::axil_wreq_t in_req,
  // User logic side
  output logic                    out_valid,
  input  logic                    out_ready,
  output rr_axil_pkg::axil_wreq_t out_req,
  // Log stream towards the merge
  output logic                    log_valid,
  input  logic                    log_ready,
  output rr_log_pkg::log_entry_t  log_entry
);

  import rr_log_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // Pass-through gating
  ////////////////////////////////////////////////////////////////////////////

  // Set on the first clock after reset, keeps in_ready low until then
  logic run_q;

  logic full;
  logic can_log;
  logic push;
  logic pop;

  // Log FIFO storage and pointers
  log_entry_t                              mem [LOG_FIFO_DEPTH];
  logic [$clog2(LOG_FIFO_DEPTH)-1:0]       wr_ptr;
  logic [$clog2(LOG_FIFO_DEPTH)-1:0]       rd_ptr;
  logic [$clog2(LOG_FIFO_DEPTH+1)-1:0]     count;

  assign full    = (count == LOG_FIFO_DEPTH);
  assign can_log = run_q && !full;

  // Both sides see the same gate
  // so a write moves through only when it is also logged
  assign out_valid = in_valid && can_log;
  assign in_ready  = out_ready && can_log;
  assign out_req   = in_req;

  // Shell-side transfer is the push
  assign push = in_valid && in_ready;
  assign pop  = log_valid && log_ready;

  ////////////////////////////////////////////////////////////////////////////
  // Log FIFO, no bypass
  ////////////////////////////////////////////////////////////////////////////

  assign log_valid = (count != '0);
  assign log_entry = mem[rd_ptr];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      run_q  <= 1'b0;
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      run_q <= 1'b1;
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // Count only moves when exactly one side fires
      unique case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Payload storage
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= '{req: in_req};
    end
  end

endmodule

`default_nettype wire

// File: hw/rr_log_merge.sv
`timescale 1ns/1ps
`default_nettype none

module rr_log_merge (
  input  logic                                            clk,
  input  logic                                            rst_n,
  // One log stream per channel, index is the channel tag
  input  logic [rr_log_pkg::CHAN_CNT-1:0]                 log_valid,
  output logic [rr_log_pkg::CHAN_CNT-1:0]                 log_ready,
  input  rr_log_pkg::log_entry_t [rr_log_pkg::CHAN_CNT-1:0] log_entry,
  // Tagged stream towards the packer
  output logic                                            tag_valid,
  input  logic                                            tag_ready,
  output rr_log_pkg::tagged_entry_t                       tag_entry
);

  import rr_log_pkg::*;

  // Channel checked first in the next arbitration
  chan_id_t rr_ptr;

  logic     take;
  logic     grant_vld;
  chan_id_t grant_id;

  // Output register is empty or being drained
  assign take = !tag_valid || tag_ready;

  ////////////////////////////////////////////////////////////////////////////
  // Round-robin arbiter
  ////////////////////////////////////////////////////////////////////////////

  // Walk the channels starting at the pointer, first valid one wins
  always_comb begin
    chan_id_t cand;
    grant_vld = 1'b0;
    grant_id  = rr_ptr;
    for (int i = 0; i < CHAN_CNT; i++) begin
      cand = rr_ptr + chan_id_t'(i);
      if (!grant_vld && log_valid[cand]) begin
        grant_vld = 1'b1;
        grant_id  = cand;
      end
    end
  end

  // Only the granted channel sees ready
  always_comb begin
    for (int i = 0; i < CHAN_CNT; i++) begin
      log_ready[i] = take && grant_vld && (grant_id == chan_id_t'(i));
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Output stage
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tag_valid <= 1'b0;
      rr_ptr    <= CHAN_OCL;
    end else begin
      if (take) begin
        tag_valid <= grant_vld;
      end
      // Move past the winner so the other channel goes first next time
      if (take && grant_vld) begin
        rr_ptr <= grant_id + 1'b1;
      end
    end
  end

  // Entry and its tag are captured together
  always_ff @(posedge clk) begin
    if (take && grant_vld) begin
      tag_entry <= '{chan: grant_id, entry: log_entry[grant_id]};
    end
  end

endmodule

`default_nettype wire

// File: hw/rr_log_packer.sv
`timescale 1ns/1ps
`default_nettype none

module rr_log_packer (
  input  logic                      clk,
  input  logic                      rst_n,
  // Tagged stream from the merge
  input  logic                      tag_valid,
  output logic                      tag_ready,
  input  rr_log_pkg::tagged_entry_t tag_entry,
  // Record stream towards writeback
  output logic                      rec_valid,
  input  logic                      rec_ready,
  output rr_log_pkg::rr_record_t    rec
);

  import rr_log_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // Check field
  ////////////////////////////////////////////////////////////////////////////

  // XOR of every byte in address and data
  // tag folded into bit 0 so swapped channels are caught
  function automatic rr_check_t calc_check(input log_entry_t entry,
                                           input chan_id_t   chan);
    logic [$bits(log_entry_t)-1:0] raw;
    rr_check_t                     acc;
    raw = entry;
    acc = rr_check_t'(chan);
    for (int b = 0; b < $bits(log_entry_t) / 8; b++) begin
      acc = acc ^ raw[b*8 +: 8];
    end
    return acc;
  endfunction

  // Next sequence number to hand out
  rr_seq_t seq_q;

  logic take;
  logic accept;

  // Same rule as the merge, free or being drained
  assign take      = !rec_valid || rec_ready;
  assign tag_ready = take;
  assign accept    = tag_valid && take;

  ////////////////////////////////////////////////////////////////////////////
  // Sequence counter and valid
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rec_valid <= 1'b0;
      seq_q     <= '0;
    end else begin
      if (take) begin
        rec_valid <= tag_valid;
      end
      // Wraps at 16 bits
      if (accept) begin
        seq_q <= seq_q + 1'b1;
      end
    end
  end

  // Record payload
  always_ff @(posedge clk) begin
    if (accept) begin
      rec <= '{seq:   seq_q,
               chan:  tag_entry.chan,
               check: calc_check(tag_entry.entry, tag_entry.chan),
               entry: tag_entry.entry};
    end
  end

endmodule

`default_nettype wire

// File: hw/rr_record_writeback.sv
`timescale 1ns/1ps
`default_nettype none

module rr_record_writeback (
  input  logic                   clk,
  input  logic                   rst_n,
  // Record stream from the packer
  input  logic                   rec_valid,
  output logic                   rec_ready,
  input  rr_log_pkg::rr_record_t rec,
  // Trace storage, credit based
  output logic                   st_valid,
  output rr_log_pkg::rr_record_t st_rec,
  input  logic                   st_credit
);

  import rr_log_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // Holding register
  ////////////////////////////////////////////////////////////////////////////

  // Record waiting for issue
  logic       pend_q;
  rr_record_t hold_q;

  // Credits left at the storage side
  credit_cnt_t credit_q;

  logic have_credit;
  logic issue;
  logic accept;

  assign have_credit = (credit_q != '0);

  // One record per cycle, only with a credit in hand
  assign issue = pend_q && have_credit;

  // Free slot, or the slot empties this cycle
  // stalls here ripple back to the recorder FIFOs
  assign rec_ready = !pend_q || issue;
  assign accept    = rec_valid && rec_ready;

  assign st_valid = issue;
  assign st_rec   = hold_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pend_q <= 1'b0;
    end else if (rec_ready) begin
      pend_q <= rec_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      hold_q <= rec;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Credit counter
  ////////////////////////////////////////////////////////////////////////////

  // Issue and return may land in the same cycle and cancel out
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      credit_q <= credit_cnt_t'(WB_CREDITS);
    end else begin
      unique case ({issue, st_credit})
        2'b10:   credit_q <= credit_q - 1'b1;
        2'b01:   credit_q <= credit_q + 1'b1;
        default: credit_q <= credit_q;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hw/rr_record_top.sv
`timescale 1ns/1ps
`default_nettype none

module rr_record_top (
  input  logic                    clk,
  input  logic                    rst_n,
  // ocl channel
  input  logic                    ocl_in_valid,
  output logic                    ocl_in_ready,
  input  rr_axil_pkg::axil_wreq_t ocl_in_req,
  output logic                    ocl_out_valid,
  input  logic                    ocl_out_ready,
  output rr_axil_pkg::axil_wreq_t ocl_out_req,
  // sda channel
  input  logic                    sda_in_valid,
  output logic                    sda_in_ready,
  input  rr_axil_pkg::axil_wreq_t sda_in_req,
  output logic                    sda_out_valid,
  input  logic                    sda_out_ready,
  output rr_axil_pkg::axil_wreq_t sda_out_req,
  // Trace storage
  output logic                    st_valid,
  output rr_log_pkg::rr_record_t  st_rec,
  input  logic                    st_credit
);

  import rr_log_pkg::*;

  // Per channel log streams, indexed by tag
  logic [CHAN_CNT-1:0]       log_valid;
  logic [CHAN_CNT-1:0]       log_ready;
  log_entry_t [CHAN_CNT-1:0] log_entry;

  // Merge to packer
  logic          tag_valid;
  logic          tag_ready;
  tagged_entry_t tag_entry;

  // Packer to writeback
  logic       rec_valid;
  logic       rec_ready;
  rr_record_t rec;

  ////////////////////////////////////////////////////////////////////////////
  // Recorders
  ////////////////////////////////////////////////////////////////////////////

  axil_mstr_recorder u_ocl_recorder (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (ocl_in_valid),
    .in_ready  (ocl_in_ready),
    .in_req    (ocl_in_req),
    .out_valid (ocl_out_valid),
    .out_ready (ocl_out_ready),
    .out_req   (ocl_out_req),
    .log_valid (log_valid[CHAN_OCL]),
    .log_ready (log_ready[CHAN_OCL]),
    .log_entry (log_entry[CHAN_OCL])
  );

  axil_mstr_recorder u_sda_recorder (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (sda_in_valid),
    .in_ready  (sda_in_ready),
    .in_req    (sda_in_req),
    .out_valid (sda_out_valid),
    .out_ready (sda_out_ready),
    .out_req   (sda_out_req),
    .log_valid (log_valid[CHAN_SDA]),
    .log_ready (log_ready[CHAN_SDA]),
    .log_entry (log_entry[CHAN_SDA])
  );

  ////////////////////////////////////////////////////////////////////////////
  // Merge, pack, write back
  ////////////////////////////////////////////////////////////////////////////

  rr_log_merge u_merge (
    .clk       (clk),
    .rst_n     (rst_n),
    .log_valid (log_valid),
    .log_ready (log_ready),
    .log_entry (log_entry),
    .tag_valid (tag_valid),
    .tag_ready (tag_ready),
    .tag_entry (tag_entry)
  );

  rr_log_packer u_packer (
    .clk       (clk),
    .rst_n     (rst_n),
    .tag_valid (tag_valid),
    .tag_ready (tag_ready),
    .tag_entry (tag_entry),
    .rec_valid (rec_valid),
    .rec_ready (rec_ready),
    .rec       (rec)
  );

  rr_record_writeback u_writeback (
    .clk       (clk),
    .rst_n     (rst_n),
    .rec_valid (rec_valid),
    .rec_ready (rec_ready),
    .rec       (rec),
    .st_valid  (st_valid),
    .st_rec    (st_rec),
    .st_credit (st_credit)
  );

endmodule

`default_nettype wire

// File: verification/tb_rr_record.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rr_record;

  import rr_axil_pkg::*;
  import rr_log_pkg::*;

  // Writes in the golden file, both channels together
  localparam int GOLD_CNT  = 19;
  localparam int CLK_HALF  = 5;
  localparam int WATCH_CYC = 200 * GOLD_CNT + 1000;
  localparam int TEST_CNT  = 5;

  logic clk;
  logic rst_n;

  // DUT inputs, index 0 is ocl and 1 is sda
  logic [1:0] in_valid;
  logic [1:0] out_ready;
  axil_wreq_t in_req [2];
  logic       st_credit;

  // DUT outputs
  logic       ocl_in_ready;
  logic       ocl_out_valid;
  axil_wreq_t ocl_out_req;
  logic       sda_in_ready;
  logic       sda_out_valid;
  axil_wreq_t sda_out_req;
  logic       st_valid;
  rr_record_t st_rec;

  // Golden writes, split per channel in issue order
  logic [31:0] gold_mem [4*GOLD_CNT];
  axil_wreq_t  gold_req [2][GOLD_CNT];
  rr_check_t   gold_chk [2][GOLD_CNT];
  int          gold_n   [2];

  // Scoreboard state
  int         out_idx [2];
  int         rec_idx [2];
  int         issued;
  int         returned;
  int         cyc;
  int         due_q [$];
  rr_record_t st_log [$];
  logic       hold_credits;
  logic [31:0] rng;

  int    errs [TEST_CNT];
  int    check_cnt;
  string test_name [TEST_CNT];
  string cur_test;

  always #CLK_HALF clk = ~clk;

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  rr_record_top u_rr_record_top (
    .clk           (clk),
    .rst_n         (rst_n),
    .ocl_in_valid  (in_valid[0]),
    .ocl_in_ready  (ocl_in_ready),
    .ocl_in_req    (in_req[0]),
    .ocl_out_valid (ocl_out_valid),
    .ocl_out_ready (out_ready[0]),
    .ocl_out_req   (ocl_out_req),
    .sda_in_valid  (in_valid[1]),
    .sda_in_ready  (sda_in_ready),
    .sda_in_req    (in_req[1]),
    .sda_out_valid (sda_out_valid),
    .sda_out_ready (out_ready[1]),
    .sda_out_req   (sda_out_req),
    .st_valid      (st_valid),
    .st_rec        (st_rec),
    .st_credit     (st_credit)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  // Xorshift32, one shared stream for gaps, ready and credit delays
  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  task automatic check_eq(input int test, input string sig,
                          input logic [127:0] expected, input logic [127:0] actual);
    check_cnt++;
    if (actual !== expected) begin
      errs[test]++;
      $display("error at %0d ns: %s expected %0h, got %0h", $time, sig, expected, actual);
    end
  endtask

  task automatic report_fail(input int test, input string what);
    errs[test]++;
    $display("failure at %0d ns: %s", $time, what);
  endtask

  task automatic report_test(input int idx);
    $display("test %0d %-14s %s, %0d errors", idx + 1, test_name[idx],
             (errs[idx] == 0) ? "passed" : "failed", errs[idx]);
  endtask

  // Inputs change 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  // Nothing may pass, be accepted or issue before the first clock after reset
  task automatic check_quiet();
    check_eq(0, "st_valid", 1'b0, st_valid);
    check_eq(0, "ocl_out_valid", 1'b0, ocl_out_valid);
    check_eq(0, "sda_out_valid", 1'b0, sda_out_valid);
    check_eq(0, "ocl_in_ready", 1'b0, ocl_in_ready);
    check_eq(0, "sda_in_ready", 1'b0, sda_in_ready);
  endtask

  task automatic load_golden();
    int ch;
    $readmemh("verification/rr_record_golden.txt", gold_mem);
    if ($isunknown(gold_mem[4*GOLD_CNT-1])) begin
      $display("golden file is missing or holds fewer than %0d writes", GOLD_CNT);
      $display("STATUS: FAIL");
      $finish;
    end
    // Four words per write: chan, addr, data, check
    for (int i = 0; i < GOLD_CNT; i++) begin
      ch = int'(gold_mem[4*i][0]);
      gold_req[ch][gold_n[ch]] = '{addr: gold_mem[4*i+1], data: gold_mem[4*i+2]};
      gold_chk[ch][gold_n[ch]] = gold_mem[4*i+3][7:0];
      gold_n[ch]++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Shell-side drivers
  ////////////////////////////////////////////////////////////////////////////

  // Back-to-back while credits are held, so both FIFOs fill
  task automatic drive_channel(input int ch);
    int   gap;
    logic fired;
    for (int i = 0; i < gold_n[ch]; i++) begin
      gap = hold_credits ? 0 : int'(next_rand() % 4);
      repeat (gap) next_cycle();
      in_valid[ch] = 1'b1;
      in_req[ch]   = gold_req[ch][i];
      fired        = 1'b0;
      // Valid and payload hold until the transfer edge
      while (!fired) begin
        @(negedge clk);
        fired = (ch == 0) ? ocl_in_ready : sda_in_ready;
        next_cycle();
      end
      in_valid[ch] = 1'b0;
    end
  endtask

  // User side ready, held high during the credit stall
  always @(posedge clk) begin
    #1;
    for (int ch = 0; ch < 2; ch++) begin
      out_ready[ch] = hold_credits || ((next_rand() % 4) != 0);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Storage model and monitors
  ////////////////////////////////////////////////////////////////////////////

  // One credit pulse per cycle at most, oldest record first
  always @(posedge clk) begin
    #1;
    st_credit = 1'b0;
    if (!hold_credits && due_q.size() > 0 && cyc >= due_q[0]) begin
      st_credit = 1'b1;
      returned++;
      void'(due_q.pop_front());
    end
  end

  task automatic check_pass(input int ch);
    logic       in_fire;
    logic       out_fire;
    axil_wreq_t req;
    string      name;
    in_fire  = in_valid[ch] && ((ch == 0) ? ocl_in_ready : sda_in_ready);
    out_fire = ((ch == 0) ? ocl_out_valid : sda_out_valid) && out_ready[ch];
    req      = (ch == 0) ? ocl_out_req : sda_out_req;
    name     = (ch == 0) ? "ocl" : "sda";
    // Both sides must move on the same edge
    if (in_fire || out_fire) begin
      check_eq(1, {name, "_out_valid"}, in_fire, out_fire);
    end
    if (out_fire) begin
      if (out_idx[ch] < gold_n[ch]) begin
        check_eq(1, {name, "_out_req"}, gold_req[ch][out_idx[ch]], req);
      end else begin
        report_fail(1, {name, " passed a write that is not in the golden file"});
      end
      out_idx[ch]++;
    end
  endtask

  task automatic take_record();
    chan_id_t ch;
    ch = st_rec.chan;
    issued++;
    st_log.push_back(st_rec);
    if (rec_idx[ch] < gold_n[ch]) begin
      check_eq(2, "st_rec.entry", gold_req[ch][rec_idx[ch]], st_rec.entry.req);
      check_eq(2, "st_rec.check", gold_chk[ch][rec_idx[ch]], st_rec.check);
    end else begin
      report_fail(2, "storage got a record beyond the golden writes of its channel");
    end
    rec_idx[ch]++;
    // Credit comes back after a random storage latency
    due_q.push_back(cyc + 1 + int'(next_rand() % 6));
  endtask

  // Sample mid-cycle, values equal those at the next rising edge
  always @(negedge clk) begin
    if (rst_n) begin
      check_pass(0);
      check_pass(1);
      if (st_valid) begin
        take_record();
      end
      if (issued - returned > WB_CREDITS) begin
        report_fail(4, $sformatf("%0d records outstanding with only %0d credits",
                                 issued - returned, WB_CREDITS));
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int total;
    int waited;
    int err_sum;
    test_name[0] = "reset";
    test_name[1] = "pass-through";
    test_name[2] = "record";
    test_name[3] = "sequencing";
    test_name[4] = "credits";
    cur_test     = "reset";
    rng          = 32'h28c5c831;
    clk          = 1'b0;
    rst_n        = 1'b0;
    // Shell already requests during reset, none of it may get through
    in_valid     = '1;
    out_ready    = '0;
    in_req[0]    = '0;
    in_req[1]    = '0;
    st_credit    = 1'b0;
    hold_credits = 1'b1;
    issued       = 0;
    returned     = 0;
    cyc          = 0;
    check_cnt    = 0;
    load_golden();
    total = gold_n[0] + gold_n[1];

    // Outputs stay quiet through reset and right after it
    repeat (10) begin
      @(negedge clk);
      check_quiet();
    end
    next_cycle();
    rst_n = 1'b1;
    @(negedge clk);
    check_quiet();
    report_test(0);

    next_cycle();
    in_valid = '0;
    fork
      drive_channel(0);
      drive_channel(1);
    join_none

    // Storage holds every credit until both channels stall
    cur_test = "credits";
    waited   = 0;
    while (!(issued == WB_CREDITS && !ocl_in_ready && !sda_in_ready) && waited < 200) begin
      @(negedge clk);
      waited++;
    end
    if (waited >= 200) begin
      report_fail(4, "channels never stalled while storage held its credits");
    end
    repeat (16) @(negedge clk);
    check_eq(4, "records issued while held", WB_CREDITS, issued);
    hold_credits = 1'b0;

    // Drain everything, then a quiet window for stray records
    cur_test = "record delivery";
    while (!(issued == total && out_idx[0] == gold_n[0] && out_idx[1] == gold_n[1])) begin
      @(negedge clk);
    end
    repeat (20) @(negedge clk);
    check_eq(1, "ocl writes passed", gold_n[0], out_idx[0]);
    check_eq(1, "sda writes passed", gold_n[1], out_idx[1]);
    check_eq(2, "ocl records", gold_n[0], rec_idx[0]);
    check_eq(2, "sda records", gold_n[1], rec_idx[1]);
    // Sequence numbers in storage order, no gaps
    for (int i = 0; i < st_log.size(); i++) begin
      check_eq(3, "st_rec.seq", rr_seq_t'(i), st_log[i].seq);
    end
    check_eq(3, "records stored", total, st_log.size());
    report_test(1);
    report_test(2);
    report_test(3);
    report_test(4);

    err_sum = 0;
    for (int i = 0; i < TEST_CNT; i++) begin
      err_sum += errs[i];
    end
    $display("tests %0d, checks %0d, errors %0d", TEST_CNT, check_cnt, err_sum);
    if (err_sum == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  // Bound on the whole run, scaled by the number of writes
  initial begin
    repeat (WATCH_CYC) @(posedge clk);
    $display("watchdog: test %s did not finish within %0d cycles", cur_test, WATCH_CYC);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: verification/rr_record_golden.txt
// Columns are chan, addr, data and expected record check field, all hex
// Chan 0 is ocl and 1 is sda, lines of one channel are in issue order
0 00001000 12345678 18
1 40000000 00000010 51
0 00001004 deadbeef 36
0 00001008 00000000 18
1 40000004 cafef00d 8c
1 40000008 00000000 49
0 0000100c ffffffff 1c
1 4000000c 11111111 4d
0 00001010 a5a5a5a5 00
1 40000010 01020304 55
0 00001014 0000ffff 04
0 00002000 00000001 21
1 40000100 000000ff bf
0 00002004 80000000 a4
1 40000104 55aa55aa 44
0 00002008 13579bdf 28
1 40000108 00000002 4a
0 0000200c 0f0f0f0f 2c
1 4000010c 7f000000 33

// File: list.f
hw/rr_axil_pkg.sv
hw/rr_log_pkg.sv
hw/axil_mstr_recorder.sv
hw/rr_log_merge.sv
hw/rr_log_packer.sv
hw/rr_record_writeback.sv
hw/rr_record_top.sv
verification/tb_rr_record.sv
